// File: build.f
hw/cart_cfg_pkg.sv
hw/bus_pkg.sv
hw/write_decode.sv
hw/config_regs.sv
hw/bank_regs.sv
hw/cycle_irq.sv
hw/addr_map.sv
hw/cart_mapper.sv
tb/cart_mapper_tb.sv

// File: tb/cart_mapper_tb.sv
`timescale 1ns/100ps

module cart_mapper_tb;
	import cart_cfg_pkg::*;

	localparam int CLK_PERIOD  = 4;
	localparam int IRQ_EDGES   = 4096;                               // SMB2j counter bit 12
	localparam int WATCHDOG_NS = (IRQ_EDGES + 900) * CLK_PERIOD * 3; // About 60 us

	logic        m2;
	logic        ppu_addr_in;
	logic        romsel;
	logic        cpu_rw;
	logic [14:0] cpu_addr;
	logic [7:0]  cpu_data;
	logic        ppu_rd;
	logic        ppu_wr;
	logic [13:0] ppu_addr;
	logic [26:13] cpu_addr_out;
	logic [17:10] ppu_addr_out;
	logic        flash_we, flash_oe, sram_ce, sram_we, sram_oe;
	logic        ppu_rd_out, ppu_wr_out, ciram_a10, irq_n;

	integer      seed = 39;
	int          errors, checks, test_errs, tests_failed, n, i;
	logic [12:0] base;        // Expected PRG base
	logic [4:0]  mask, cmask; // Expected PRG and CHR masks
	logic [4:0]  bank, chr0, chr1;
	logic [5:0]  bank6;
	logic [1:0]  page;
	logic [13:0] ppa;

	cart_mapper uut (
		.m2, .ppu_addr_in, .romsel, .cpu_rw, .cpu_addr, .cpu_data, .ppu_rd, .ppu_wr,
		.ppu_addr, .cpu_addr_out, .flash_we, .flash_oe, .sram_ce, .sram_we, .sram_oe,
		.ppu_addr_out, .ppu_rd_out, .ppu_wr_out, .ciram_a10, .irq_n
	);

	initial
	begin
		m2 = 1'b0;
		forever #(CLK_PERIOD / 2) m2 = ~m2;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired at %0t ns, the tests did not complete", $time);
		$display("** FAIL **");
		$finish;
	end

	// One CPU cycle, sampled 1 ns into the m2 high phase
	task automatic bus_cycle(input logic rs, input logic rw, input logic [14:0] a,
		input logic [7:0] d);
		@(posedge m2);
		romsel   <= rs;
		cpu_rw   <= rw;
		cpu_addr <= a;
		cpu_data <= d;
		#1;
	endtask

	task automatic cfg_write(input cfg_index_t idx, input logic [7:0] d);
		bus_cycle(1'b1, 1'b0, {12'hA00, idx}, d); // $5000 + index
	endtask

	task automatic ppu_cycle(input logic [13:0] a);
		@(posedge m2);
		romsel   <= 1'b1; // CPU bus idle
		cpu_rw   <= 1'b1;
		ppu_addr <= a;
		ppu_rd   <= 1'b0;
		ppu_wr   <= 1'b1;
		#1;
	endtask

	task automatic chr_write_cycle(input logic [13:0] a);
		@(posedge m2);
		romsel   <= 1'b1; // CPU bus idle
		cpu_rw   <= 1'b1;
		ppu_addr <= a;
		ppu_rd   <= 1'b1;
		ppu_wr   <= 1'b0;
		#1;
	endtask

	task automatic mmc1_load(input logic [14:0] a, input logic [4:0] v);
		for (int k = 0; k < 5; k++)
			bus_cycle(1'b0, 1'b0, a, {7'b0, v[k]}); // LSB first
	endtask

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		assert (got === exp)
		else
		begin
			$display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			test_errs++;
		end
	endtask

	task automatic end_test(input int num, input string name);
		$display("Test %0d %s: %0d errors", num, name, test_errs);
		if (test_errs != 0)
			tests_failed++;
		errors += test_errs;
		test_errs = 0;
	endtask

	// Flash A26..A13 for an 8 KiB bank, base ORed with masked bank
	function automatic logic [13:0] rom_exp(input logic [5:0] bank8k);
		rom_exp = {base | {8'b0, bank8k[5:1] & ~mask}, bank8k[0]};
	endfunction

	function automatic logic [7:0] chr_exp(input logic [7:0] a17_10);
		chr_exp = {a17_10[7:3] & ~cmask, a17_10[2:0]};
	endfunction

	initial
	begin
		ppu_addr_in = 1'b1;
		romsel      = 1'b1;
		cpu_rw      = 1'b1;
		cpu_addr    = '0;
		cpu_data    = '0;
		ppu_rd      = 1'b1;
		ppu_wr      = 1'b1;
		ppu_addr    = '0;
		base        = '0;
		mask        = '0;
		cmask       = '0;
		repeat (8) @(posedge m2);
		ppu_addr_in <= 1'b0;

		bus_cycle(1'b0, 1'b0, 15'h0000, 8'h00); // $8000 write, NROM has no latch
		check(irq_n, 1'b1, "irq_n after reset");
		check(flash_we, 1'b1, "flash_we after reset");
		check(flash_oe, 1'b1, "flash_oe on a write");
		check(sram_we, 1'b0, "sram_we on a write");
		check(sram_oe, 1'b1, "sram_oe on a write");
		bus_cycle(1'b0, 1'b1, 15'h0000, 8'h00);
		check(cpu_addr_out, rom_exp(6'd0), "$8000 after reset");
		check(flash_oe, 1'b0, "flash_oe on a ROM read");
		check(sram_we, 1'b1, "sram_we on a read");
		check(sram_oe, 1'b0, "sram_oe on a read");
		bus_cycle(1'b1, 1'b1, 15'h6000, 8'h00);
		check(cpu_addr_out, 14'h0000, "$6000 SRAM page after reset");
		check(sram_ce, 1'b1, "sram_ce after reset");
		check(flash_oe, 1'b1, "flash_oe at $6000 without ROM");
		end_test(1, "reset state");

		base = $random(seed);
		mask = $random(seed);
		bank = $random(seed);
		page = $random(seed);
		cfg_write(CFG_BASE_HI, {3'b0, base[12:8]});
		cfg_write(CFG_BASE_LO, base[7:0]);
		cfg_write(CFG_PRG_MASK, {3'b0, mask});
		cfg_write(CFG_SRAM_PAGE, {6'b0, page});
		cfg_write(CFG_MAPPER, MAP_UXROM);
		bus_cycle(1'b0, 1'b0, 15'h0000, {3'b0, bank}); // Bank latch, flash still protected
		check(flash_we, 1'b1, "flash_we with prg_write_en clear");
		bus_cycle(1'b0, 1'b1, 15'h0000, 8'h00);
		check(cpu_addr_out, rom_exp({bank, 1'b0}), "UxROM $8000");
		bus_cycle(1'b0, 1'b1, 15'h4000, 8'h00);
		check(cpu_addr_out, rom_exp(6'd62), "UxROM $C000 last bank");
		bus_cycle(1'b1, 1'b1, 15'h6000, 8'h00);
		check(cpu_addr_out, {12'b0, page}, "SRAM page at $6000");
		cfg_write(CFG_ENABLES, 8'h04); // PRG flash writes on
		bus_cycle(1'b0, 1'b0, 15'h0000, {3'b0, bank});
		check(flash_we, 1'b0, "flash_we with prg_write_en set");
		end_test(2, "config and UxROM");

		cmask = $random(seed);
		bank  = $random(seed);
		ppa   = $random(seed) & 14'h1fff; // Pattern table space
		cfg_write(CFG_CHR_MASK, {3'b0, cmask});
		cfg_write(CFG_MAPPER, MAP_CNROM);
		bus_cycle(1'b0, 1'b0, 15'h0000, {3'b0, bank});
		ppu_cycle(ppa);
		check(ppu_addr_out, chr_exp({bank, ppa[12:10]}), "CNROM CHR bank");
		check(ppu_rd_out, 1'b0, "ppu_rd_out in pattern space");
		check(ppu_wr_out, 1'b1, "ppu_wr_out on a PPU read");
		ppu_cycle(ppa | 14'h2000); // Nametable space
		check(ppu_rd_out, 1'b1, "ppu_rd_out in nametable space");
		chr_write_cycle(ppa);
		check(ppu_wr_out, 1'b1, "ppu_wr_out with chr_write_en clear");
		cfg_write(CFG_ENABLES, 8'h02); // CHR RAM writes on
		chr_write_cycle(ppa);
		check(ppu_wr_out, 1'b0, "ppu_wr_out with chr_write_en set");
		bank = $random(seed) & 5'h0f;
		cfg_write(CFG_MAPPER, MAP_AXROM);
		bus_cycle(1'b0, 1'b0, 15'h0000, {3'b0, bank}); // Bit 4 clear, screen A
		bus_cycle(1'b0, 1'b1, 15'h0000, 8'h00);
		check(cpu_addr_out, rom_exp({bank[3:0], 2'b00}), "AxROM 32K bank");
		for (i = 0; i < 3; i++)
		begin
			ppu_cycle($random(seed));
			check(ciram_a10, 1'b0, "AxROM screen A");
		end
		bus_cycle(1'b0, 1'b0, 15'h0000, {4'b0001, bank[3:0]}); // Screen B
		for (i = 0; i < 3; i++)
		begin
			ppu_cycle($random(seed));
			check(ciram_a10, 1'b1, "AxROM screen B");
		end
		end_test(3, "CNROM and AxROM");

		bank = $random(seed) & 5'h0f;
		chr0 = $random(seed) & 5'h0f; // Lower 256K PRG half
		chr1 = $random(seed);
		cfg_write(CFG_MAPPER, MAP_MMC1);
		mmc1_load(15'h6000, bank);
		mmc1_load(15'h2000, chr0);
		mmc1_load(15'h4000, chr1);
		mmc1_load(15'h0000, 5'b11110); // 4K CHR, fixed last, vertical
		bus_cycle(1'b0, 1'b1, 15'h0000, 8'h00);
		check(cpu_addr_out, rom_exp({1'b0, bank[3:0], 1'b0}), "MMC1 $8000");
		bus_cycle(1'b0, 1'b1, 15'h4000, 8'h00);
		check(cpu_addr_out, rom_exp(6'd30), "MMC1 $C000 fixed last");
		for (i = 0; i < 4; i++)
		begin
			ppa = $random(seed) & 14'h1fff;
			ppu_cycle(ppa);
			check(ppu_addr_out, chr_exp({1'b0, ppa[12] ? chr1 : chr0, ppa[11:10]}),
				"MMC1 4K CHR");
			check(ciram_a10, ppa[10], "MMC1 vertical mirroring");
		end
		for (i = 0; i < 3; i++)
			bus_cycle(1'b0, 1'b0, 15'h6000, {7'b0, ~bank[i]});
		bus_cycle(1'b0, 1'b0, 15'h6000, 8'h80); // Drops the three bits
		for (i = 0; i < 4; i++)
			bus_cycle(1'b0, 1'b0, 15'h6000, 8'h01);
		bus_cycle(1'b0, 1'b1, 15'h0000, 8'h00);
		check(cpu_addr_out, rom_exp({1'b0, bank[3:0], 1'b0}), "MMC1 $8000 after partial load");
		end_test(4, "MMC1");

		bank6 = $random(seed);
		cfg_write(CFG_MAPPER, MAP_SMB2J);
		bus_cycle(1'b0, 1'b0, 15'h6000, {2'b0, bank6});
		bus_cycle(1'b1, 1'b1, 15'h6000, 8'h00);
		check(cpu_addr_out, rom_exp(6'd6), "SMB2j $6000 bank 6");
		bus_cycle(1'b0, 1'b1, 15'h0000, 8'h00);
		check(cpu_addr_out, rom_exp(6'd4), "SMB2j $8000 bank 4");
		bus_cycle(1'b0, 1'b1, 15'h4000, 8'h00);
		check(cpu_addr_out, rom_exp(bank6), "SMB2j $C000 switchable");
		bus_cycle(1'b0, 1'b0, 15'h2000, 8'h00); // Counter enable
		bus_cycle(1'b1, 1'b1, 15'h0000, 8'h00); // Edge that takes the write
		check(irq_n, 1'b1, "irq_n right after enable");
		n = 0;
		while (irq_n && n < IRQ_EDGES + 16)
		begin
			@(posedge m2);
			#1;
			n++;
		end
		if (irq_n)
		begin
			$display("irq_n did not fall within %0d cycles of the enable write", n);
			test_errs++;
		end
		else
			check(n, IRQ_EDGES, "cycles from enable to irq_n low");
		bus_cycle(1'b0, 1'b0, 15'h0000, 8'h00); // Acknowledge
		bus_cycle(1'b1, 1'b1, 15'h0000, 8'h00);
		check(irq_n, 1'b1, "irq_n after acknowledge");
		end_test(5, "SMB2j IRQ");

		cfg_write(CFG_ENABLES, 8'h80);
		cfg_write(CFG_BASE_HI, {3'b0, ~base[12:8]});
		cfg_write(CFG_BASE_LO, ~base[7:0]);
		cfg_write(CFG_PRG_MASK, {3'b0, ~mask});
		cfg_write(CFG_MAPPER, MAP_UXROM);
		bus_cycle(1'b0, 1'b1, 15'h0000, 8'h00);
		check(cpu_addr_out, rom_exp(6'd4), "$8000 with lockout set");
		@(posedge m2);
		ppu_addr_in <= 1'b1;
		repeat (8) @(posedge m2);
		ppu_addr_in <= 1'b0;
		base = {5'b0, 8'($random(seed))};
		mask = '0;
		cfg_write(CFG_BASE_LO, base[7:0]);
		bus_cycle(1'b0, 1'b1, 15'h0000, 8'h00);
		check(cpu_addr_out, rom_exp(6'd0), "$8000 after reset clears lockout");
		end_test(6, "lockout");

		$display("Summary: %0d of 6 tests failed, %0d checks, %0d errors",
			tests_failed, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: hw/cart_mapper.sv
`timescale 1ns/100ps

module cart_mapper #(
	parameter bit USE_MMC1  = 1,
	parameter bit USE_SMB2J = 1
) (
	input  logic        m2,
	input  logic        ppu_addr_in,  // Async reset, active high
	input  logic        romsel,
	input  logic        cpu_rw,
	input  logic [14:0] cpu_addr,
	input  logic [7:0]  cpu_data,
	input  logic        ppu_rd,
	input  logic        ppu_wr,
	input  logic [13:0] ppu_addr,
	output logic [26:13] cpu_addr_out,
	output logic        flash_we,
	output logic        flash_oe,
	output logic        sram_ce,
	output logic        sram_we,
	output logic        sram_oe,
	output logic [17:10] ppu_addr_out,
	output logic        ppu_rd_out,
	output logic        ppu_wr_out,
	output logic        ciram_a10,
	output logic        irq_n
);
	import cart_cfg_pkg::*;
	import bus_pkg::*;

	wr_op_t                 wr_op;
	cfg_index_t             cfg_sel;
	mapper_code_t           mapper;
	logic [PRG_BASE_W-1:0]  prg_base;
	logic [PRG_MASK_W-1:0]  prg_mask;
	logic [CHR_MASK_W-1:0]  chr_mask;
	logic [1:0]             sram_page;
	logic [1:0]             mirroring;    // From $5xx7
	logic [4:0]             cfg_chr_bank;
	logic                   map_rom_on_6000;
	logic                   prg_write_en;
	logic                   chr_write_en;
	logic                   sram_en;
	logic [5:0]             prg_bank;
	logic [4:0]             chr_bank0;
	logic [4:0]             chr_bank1;
	logic [2:0]             mmc1_ctrl;
	logic [1:0]             mirror_sel;   // Effective mirroring

	write_decode #(.USE_MMC1(USE_MMC1), .USE_SMB2J(USE_SMB2J)) u_decode (
		.romsel, .cpu_rw, .cpu_addr, .mapper,
		.cpu_data7(cpu_data[7]),
		.wr_op, .cfg_sel
	);

	config_regs u_cfg (
		.m2, .ppu_addr_in, .wr_op, .cfg_sel, .cpu_data,
		.prg_base, .prg_mask, .chr_mask, .sram_page, .mapper, .mirroring,
		.cfg_chr_bank, .map_rom_on_6000, .prg_write_en, .chr_write_en, .sram_en
	);

	bank_regs #(.USE_MMC1(USE_MMC1), .USE_SMB2J(USE_SMB2J)) u_banks (
		.m2, .ppu_addr_in, .wr_op, .cpu_addr, .cpu_data, .mapper, .mirroring,
		.cfg_chr_bank, .prg_bank, .chr_bank0, .chr_bank1, .mmc1_ctrl, .mirror_sel
	);

	cycle_irq #(.USE_SMB2J(USE_SMB2J)) u_irq (
		.m2, .ppu_addr_in, .wr_op, .irq_n
	);

	addr_map #(.USE_MMC1(USE_MMC1), .USE_SMB2J(USE_SMB2J)) u_map (
		.romsel, .cpu_rw, .cpu_addr, .m2, .ppu_addr, .ppu_rd, .ppu_wr, .mapper,
		.prg_base, .prg_mask, .chr_mask, .sram_page, .map_rom_on_6000,
		.prg_write_en, .chr_write_en, .sram_en, .prg_bank, .chr_bank0,
		.chr_bank1, .mmc1_ctrl, .mirror_sel,
		.cpu_addr_out, .ppu_addr_out, .ciram_a10, .flash_we, .flash_oe,
		.sram_ce, .sram_we, .sram_oe, .ppu_rd_out, .ppu_wr_out
	);

endmodule

// File: hw/addr_map.sv
`timescale 1ns/100ps

module addr_map #(
	parameter bit USE_MMC1  = 1,
	parameter bit USE_SMB2J = 1
) (
	input  logic                                romsel,
	input  logic                                cpu_rw,
	input  logic [14:0]                         cpu_addr,
	input  logic                                m2,
	input  logic [13:0]                         ppu_addr,
	input  logic                                ppu_rd,
	input  logic                                ppu_wr,
	input  cart_cfg_pkg::mapper_code_t          mapper,
	input  logic [cart_cfg_pkg::PRG_BASE_W-1:0] prg_base,
	input  logic [cart_cfg_pkg::PRG_MASK_W-1:0] prg_mask,
	input  logic [cart_cfg_pkg::CHR_MASK_W-1:0] chr_mask,
	input  logic [1:0]                          sram_page,
	input  logic                                map_rom_on_6000,
	input  logic                                prg_write_en,
	input  logic                                chr_write_en,
	input  logic                                sram_en,
	input  logic [5:0]                          prg_bank,
	input  logic [4:0]                          chr_bank0,
	input  logic [4:0]                          chr_bank1,
	input  logic [2:0]                          mmc1_ctrl,
	input  logic [1:0]                          mirror_sel,
	output logic [26:13]                        cpu_addr_out,
	output logic [17:10]                        ppu_addr_out,
	output logic                                ciram_a10,
	output logic                                flash_we,
	output logic                                flash_oe,
	output logic                                sram_ce,
	output logic                                sram_we,
	output logic                                sram_oe,
	output logic                                ppu_rd_out,
	output logic                                ppu_wr_out
);
	import cart_cfg_pkg::*;
	import bus_pkg::*;

	logic [5:0] prg_mapped; // A18..A13
	logic [7:0] chr_mapped; // A17..A10
	logic       smb_on;
	logic       rom_6000;
	logic       win_6000;   // $6000-$7FFF while m2 high
	logic       rom_access;

	assign smb_on     = USE_SMB2J && mapper == MAP_SMB2J;
	assign rom_6000   = map_rom_on_6000 | smb_on; // SMB2j always has ROM at $6000
	assign win_6000   = m2 & romsel & (cpu_addr[14:13] == WRAM_REGION);
	assign rom_access = ~romsel | (win_6000 & rom_6000);

	always_comb
	begin
		if (USE_MMC1 && mapper == MAP_MMC1)
		begin
			case (mmc1_ctrl[1:0]) // CHR0 bit 4 picks the 256K half
				2'b10:   prg_mapped = {chr_bank0[4], cpu_addr[14] ? prg_bank[3:0] : 4'b0000,
					cpu_addr[13]}; // First bank fixed
				2'b11:   prg_mapped = {chr_bank0[4], cpu_addr[14] ? 4'b1111 : prg_bank[3:0],
					cpu_addr[13]}; // Last bank fixed
				default: prg_mapped = {chr_bank0[4], prg_bank[3:1], cpu_addr[14:13]}; // 32K
			endcase
			if (mmc1_ctrl[2]) // 4K CHR halves
				chr_mapped = {1'b0, ppu_addr[12] ? chr_bank1 : chr_bank0, ppu_addr[11:10]};
			else
				chr_mapped = {1'b0, chr_bank0[4:1], ppu_addr[12:10]};
		end
		else if (smb_on)
		begin
			case ({~romsel, cpu_addr[14:13]})
				3'b100:  prg_mapped = SMB_FIXED_8000;
				3'b101:  prg_mapped = SMB_FIXED_A000;
				3'b110:  prg_mapped = prg_bank;       // Switchable $C000
				3'b111:  prg_mapped = SMB_FIXED_E000;
				default: prg_mapped = SMB_FIXED_6000;
			endcase
			chr_mapped = {chr_bank0, ppu_addr[12:10]};
		end
		else if (mapper[3]) // AxROM-like, one 32K bank
		begin
			prg_mapped = {prg_bank[3:0], cpu_addr[14:13]};
			chr_mapped = {chr_bank0, ppu_addr[12:10]};
		end
		else // UxROM-like, last 16K fixed at $C000
		begin
			prg_mapped = {cpu_addr[14] ? 5'b11111 : prg_bank[4:0], cpu_addr[13]};
			chr_mapped = {chr_bank0, ppu_addr[12:10]};
		end
	end

	assign cpu_addr_out = rom_access ?
		{prg_base | {{(PRG_BASE_W-PRG_MASK_W){1'b0}}, prg_mapped[5:1] & ~prg_mask},
			prg_mapped[0]} :
		{12'b0, sram_page}; // SRAM page on A14..A13
	assign ppu_addr_out = {chr_mapped[7:3] & ~chr_mask, chr_mapped[2:0]};

	always_comb
	begin
		case (mirror_sel)
			MIRROR_VERT: ciram_a10 = ppu_addr[10];
			MIRROR_HORZ: ciram_a10 = ppu_addr[11];
			MIRROR_1SA:  ciram_a10 = 1'b0;
			default:     ciram_a10 = 1'b1;
		endcase
	end

	assign flash_we   = cpu_rw | romsel | ~prg_write_en; // Flash writes only via $8000+
	assign flash_oe   = ~cpu_rw | ~rom_access;
	assign sram_ce    = ~(win_6000 & sram_en & ~rom_6000);
	assign sram_we    = cpu_rw;
	assign sram_oe    = ~cpu_rw;
	assign ppu_rd_out = ppu_rd | ppu_addr[13];               // Pattern space only
	assign ppu_wr_out = ppu_wr | ppu_addr[13] | ~chr_write_en;

endmodule

// File: hw/cycle_irq.sv
`timescale 1ns/100ps

module cycle_irq #(
	parameter bit USE_SMB2J = 1
) (
	input  logic            m2,
	input  logic            ppu_addr_in,
	input  bus_pkg::wr_op_t wr_op,
	output logic            irq_n
);
	import bus_pkg::*;

	logic [SMB_IRQ_W-1:0] count;
	logic [SMB_IRQ_W-1:0] count_next;
	logic                 enable;

	assign count_next = count + 1'b1;

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			count  <= '0;
			enable <= 1'b0;
			irq_n  <= 1'b1;
		end
		else if (USE_SMB2J && wr_op == WR_SMB_ENABLE)
		begin
			count  <= '0; // Restart from zero, IRQ line untouched
			enable <= 1'b1;
		end
		else if (USE_SMB2J && wr_op == WR_SMB_ACK)
		begin
			enable <= 1'b0;
			irq_n  <= 1'b1; // Acknowledge
		end
		else if (enable)
		begin
			count <= count_next;
			irq_n <= ~count_next[SMB_IRQ_W-1]; // Low from count 4096
		end
	end

endmodule

// File: hw/bank_regs.sv
`timescale 1ns/100ps

module bank_regs #(
	parameter bit USE_MMC1  = 1,
	parameter bit USE_SMB2J = 1
) (
	input  logic                       m2,
	input  logic                       ppu_addr_in,
	input  bus_pkg::wr_op_t            wr_op,
	input  logic [14:0]                cpu_addr,
	input  logic [7:0]                 cpu_data,
	input  cart_cfg_pkg::mapper_code_t mapper,
	input  logic [1:0]                 mirroring,
	input  logic [4:0]                 cfg_chr_bank,
	output logic [5:0]                 prg_bank,
	output logic [4:0]                 chr_bank0,
	output logic [4:0]                 chr_bank1,
	output logic [2:0]                 mmc1_ctrl,  // {CHR 4K mode, PRG mode}
	output logic [1:0]                 mirror_sel
);
	import cart_cfg_pkg::*;
	import bus_pkg::*;

	logic [5:0] shift_q;    // MMC1 serial load register
	logic [5:0] shift_next;
	logic [4:0] chr0_q;     // CNROM latch or MMC1 CHR0
	logic [1:0] mirror_q;   // Mapper-driven mirroring

	assign shift_next = {cpu_data[0], shift_q[5:1]}; // LSB first

	// CNROM and MMC1 own CHR0, other mappers use the $5xx3 preset
	assign chr_bank0 = (mapper == MAP_CNROM || (USE_MMC1 && mapper == MAP_MMC1)) ?
		chr0_q : cfg_chr_bank;
	assign mirror_sel = (mapper == MAP_AXROM || (USE_MMC1 && mapper == MAP_MMC1)) ?
		mirror_q : mirroring;

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			prg_bank  <= '0;
			chr0_q    <= '0;
			chr_bank1 <= '0;
			mmc1_ctrl <= '0;
			mirror_q  <= MIRROR_VERT;
			shift_q   <= MMC1_SHIFT_RESET;
		end
		else
		begin
			case (wr_op)
				WR_BANK:
				begin
					case (mapper)
						MAP_UXROM: prg_bank <= cpu_data[5:0];
						MAP_CNROM: chr0_q <= cpu_data[4:0];
						MAP_AXROM:
						begin
							prg_bank <= {1'b0, cpu_data[4:0]}; // 32K bank in bits 3..0
							mirror_q <= cpu_data[4] ? MIRROR_1SB : MIRROR_1SA;
						end
						default: ;
					endcase
				end
				WR_MMC1_RESET:
					if (USE_MMC1)
					begin
						shift_q        <= MMC1_SHIFT_RESET;
						mmc1_ctrl[1:0] <= 2'b11; // Fixed-last PRG mode
					end
				WR_MMC1_SHIFT:
					if (USE_MMC1)
					begin
						if (shift_next[0]) // Fifth bit, marker reached bit 0
						begin
							case (cpu_addr[14:13])
								2'b00: {mmc1_ctrl, mirror_q} <= shift_next[5:1] ^ 5'b00010;
								2'b01: chr0_q <= shift_next[5:1];
								2'b10: chr_bank1 <= shift_next[5:1];
								2'b11: prg_bank <= {1'b0, shift_next[5:1]};
							endcase
							shift_q <= MMC1_SHIFT_RESET;
						end
						else
							shift_q <= shift_next;
					end
				WR_SMB_BANK:
					if (USE_SMB2J)
						prg_bank <= cpu_data[5:0]; // 8K bank at $C000
				default: ;
			endcase
		end
	end

endmodule

// File: hw/config_regs.sv
`timescale 1ns/100ps

module config_regs (
	input  logic                                   m2,
	input  logic                                   ppu_addr_in,
	input  bus_pkg::wr_op_t                        wr_op,
	input  cart_cfg_pkg::cfg_index_t               cfg_sel,
	input  logic [7:0]                             cpu_data,
	output logic [cart_cfg_pkg::PRG_BASE_W-1:0]    prg_base,
	output logic [cart_cfg_pkg::PRG_MASK_W-1:0]    prg_mask,
	output logic [cart_cfg_pkg::CHR_MASK_W-1:0]    chr_mask,
	output logic [1:0]                             sram_page,
	output cart_cfg_pkg::mapper_code_t             mapper,
	output logic [1:0]                             mirroring,
	output logic [4:0]                             cfg_chr_bank,
	output logic                                   map_rom_on_6000,
	output logic                                   prg_write_en,
	output logic                                   chr_write_en,
	output logic                                   sram_en
);
	import cart_cfg_pkg::*;
	import bus_pkg::*;

	logic lockout; // Freezes all $5xxx registers until reset

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			prg_base        <= '0;
			prg_mask        <= '0;
			chr_mask        <= '0;
			sram_page       <= '0;
			mapper          <= MAP_NROM;
			mirroring       <= MIRROR_VERT;
			cfg_chr_bank    <= '0;
			map_rom_on_6000 <= 1'b0;
			prg_write_en    <= 1'b0;
			chr_write_en    <= 1'b0;
			sram_en         <= 1'b0;
			lockout         <= 1'b0;
		end
		else if (wr_op == WR_CFG && !lockout)
		begin
			case (cfg_sel)
				CFG_BASE_HI:   prg_base[12:8] <= cpu_data[4:0]; // A26..A22
				CFG_BASE_LO:   prg_base[7:0] <= cpu_data;       // A21..A14
				CFG_PRG_MASK:  prg_mask <= cpu_data[PRG_MASK_W-1:0];
				CFG_CHR_BANK:  cfg_chr_bank <= cpu_data[4:0];   // Preset for simple mappers
				CFG_CHR_MASK:  chr_mask <= cpu_data[CHR_MASK_W-1:0];
				CFG_SRAM_PAGE: sram_page <= cpu_data[1:0];
				CFG_MAPPER:    mapper <= mapper_code_t'(cpu_data[4:0]);
				CFG_ENABLES:
				begin
					lockout         <= cpu_data[7];
					map_rom_on_6000 <= cpu_data[5];
					mirroring       <= cpu_data[4:3];
					prg_write_en    <= cpu_data[2];
					chr_write_en    <= cpu_data[1];
					sram_en         <= cpu_data[0];
				end
				default: ;
			endcase
		end
	end

endmodule

// File: hw/write_decode.sv
`timescale 1ns/100ps

module write_decode #(
	parameter bit USE_MMC1  = 1,
	parameter bit USE_SMB2J = 1
) (
	input  logic                       romsel,
	input  logic                       cpu_rw,
	input  logic [14:0]                cpu_addr,
	input  cart_cfg_pkg::mapper_code_t mapper,
	input  logic                       cpu_data7,
	output bus_pkg::wr_op_t            wr_op,
	output cart_cfg_pkg::cfg_index_t   cfg_sel
);
	import cart_cfg_pkg::*;
	import bus_pkg::*;

	assign cfg_sel = cfg_index_t'(cpu_addr[2:0]); // $5xx0..$5xx7

	always_comb
	begin
		wr_op = WR_NONE;
		if (!cpu_rw) // Writes only
		begin
			if (romsel) // $0000-$7FFF
			begin
				if (cpu_addr[14:12] == CFG_REGION)
					wr_op = WR_CFG; // Lockout handled downstream
			end
			else // $8000-$FFFF
			begin
				case (mapper)
					MAP_UXROM, MAP_CNROM, MAP_AXROM: wr_op = WR_BANK;
					MAP_MMC1:
						if (USE_MMC1)
							wr_op = cpu_data7 ? WR_MMC1_RESET : WR_MMC1_SHIFT;
					MAP_SMB2J:
						if (USE_SMB2J)
						begin
							case (cpu_addr[14:13])
								2'b00:   wr_op = WR_SMB_ACK;    // $8000
								2'b01:   wr_op = WR_SMB_ENABLE; // $A000
								2'b11:   wr_op = WR_SMB_BANK;   // $E000
								default: wr_op = WR_NONE;       // $C000 unused
							endcase
						end
					default: wr_op = WR_NONE; // NROM has no registers
				endcase
			end
		end
	end

endmodule

// File: hw/bus_pkg.sv
package bus_pkg;

	// One decoded CPU write per m2 cycle
	typedef enum logic [2:0] {
		WR_NONE,       // Read or unmapped write
		WR_CFG,        // $5000-$5FFF config write
		WR_BANK,       // UxROM, CNROM, AxROM latch
		WR_MMC1_RESET, // Data bit 7 set
		WR_MMC1_SHIFT, // One serial bit
		WR_SMB_ACK,    // $8000-$9FFF
		WR_SMB_ENABLE, // $A000-$BFFF
		WR_SMB_BANK    // $E000-$FFFF
	} wr_op_t;

	localparam logic [2:0] CFG_REGION  = 3'b101; // A14..A12 of $5xxx
	localparam logic [1:0] WRAM_REGION = 2'b11;  // A14..A13 of $6000-$7FFF

	// SMB2j fixed 8 KiB banks
	localparam logic [5:0] SMB_FIXED_6000 = 6'd6, SMB_FIXED_8000 = 6'd4,
		SMB_FIXED_A000 = 6'd5, SMB_FIXED_E000 = 6'd7;

	localparam int SMB_IRQ_W = 13; // IRQ fires when bit 12 sets

endpackage

// File: hw/cart_cfg_pkg.sv
package cart_cfg_pkg;

	// Mapper select codes in $5xx6 bits 4..0
	typedef enum logic [4:0] {
		MAP_NROM  = 5'd0,
		MAP_UXROM = 5'd1,
		MAP_CNROM = 5'd2,
		MAP_AXROM = 5'd8,
		MAP_MMC1  = 5'd16,
		MAP_SMB2J = 5'd18
	} mapper_code_t;

	localparam int PRG_BASE_W = 13; // A26..A14
	localparam int PRG_MASK_W = 5;  // A18..A14
	localparam int CHR_MASK_W = 5;  // A17..A13

	// Register index from A2..A0 of a $5xxx write
	typedef enum logic [2:0] {
		CFG_BASE_HI,   // $5xx0
		CFG_BASE_LO,   // $5xx1
		CFG_PRG_MASK,  // $5xx2
		CFG_CHR_BANK,  // $5xx3
		CFG_CHR_MASK,  // $5xx4
		CFG_SRAM_PAGE, // $5xx5
		CFG_MAPPER,    // $5xx6
		CFG_ENABLES    // $5xx7
	} cfg_index_t;

	localparam logic [1:0] MIRROR_VERT = 2'b00; // CIRAM A10 from PPU A10
	localparam logic [1:0] MIRROR_HORZ = 2'b01; // CIRAM A10 from PPU A11
	localparam logic [1:0] MIRROR_1SA  = 2'b10; // Single screen, page A
	localparam logic [1:0] MIRROR_1SB  = 2'b11; // Single screen, page B

	// Marker bit walks down to bit 0 after five serial writes
	localparam logic [5:0] MMC1_SHIFT_RESET = 6'b100000;

endpackage
